// File: include/msi_defines.svh
//////////////////////////////////////////////////
// Width and code macros for the MSI bridge
// Interrupt count, AXI4-Lite address/data/strobe
// widths, device and event id widths, throttle
// counter width and the OKAY response code
//////////////////////////////////////////////////

`ifndef MSI_DEFINES_SVH
`define MSI_DEFINES_SVH

// Number of level interrupt lines
`define MSI_NUM_IRQ 4

// AXI4-Lite write channel widths
`define MSI_ADDR_W 32
`define MSI_DATA_W 32
`define MSI_STRB_W 4

// Per-line configuration fields
`define MSI_DEVID_W 16
`define MSI_EVID_W 16

// Throttle down-counter width
`define MSI_THR_W 8

// AXI response codes
`define MSI_RESP_OKAY 2'b00

`endif

// File: design/msi_pkg.sv
//////////////////////////////////////////////////
// Shared types of the MSI bridge
// Per-line configuration struct, captured message
// struct and the interrupt index width
//////////////////////////////////////////////////

`default_nettype none

`include "msi_defines.svh"

package msi_pkg;

  // Index width of one interrupt line
  localparam int msi_idx_w = (`MSI_NUM_IRQ > 1) ? $clog2(`MSI_NUM_IRQ) : 1;

  // One line's message configuration
  // device_id goes into the address, event_id into the data
  typedef struct packed {
    logic [`MSI_DEVID_W-1:0] device_id;
    logic [`MSI_EVID_W-1:0]  event_id;
  } msi_irq_cfg_t;

  // Captured message, payload of one AXI4-Lite write
  typedef struct packed {
    logic [`MSI_ADDR_W-1:0] addr;
    logic [`MSI_DATA_W-1:0] data;
    logic [`MSI_STRB_W-1:0] strb;
  } msi_msg_t;

endpackage

`default_nettype wire

// File: design/msi_irq_pending.sv
//////////////////////////////////////////////////
// Interrupt edge detection and pending bits
// Sets a pending bit on each enabled rising edge,
// merges repeats, and picks the next line to serve
// round-robin from a rotating pointer
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_irq_pending
  import msi_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`MSI_NUM_IRQ-1:0] irq,
  input  logic [`MSI_NUM_IRQ-1:0] msi_enable,
  input  logic                    grant,
  output logic                    req_valid,
  output logic [msi_idx_w-1:0]    req_idx
);

  logic [`MSI_NUM_IRQ-1:0] irq_q;
  logic [`MSI_NUM_IRQ-1:0] irq_rise;
  logic [`MSI_NUM_IRQ-1:0] pending;
  logic [`MSI_NUM_IRQ-1:0] clear;
  logic [msi_idx_w-1:0]    rr_ptr;

  // Previous irq level, sampled through reset as well
  // so a line already high at reset release is no edge
  always_ff @(posedge clk) begin
    irq_q <= irq;
  end

  // Enabled rising edges only
  assign irq_rise = irq & ~irq_q & msi_enable;

  // One-hot clear of the granted line
  always_comb begin
    clear = '0;
    if (grant) begin
      clear[req_idx] = 1'b1;
    end
  end

  // Set wins over clear, so an edge on the grant cycle
  // leaves the line pending for another write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clear) | irq_rise;
    end
  end

  // Pointer moves one past each granted line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (grant) begin
      if (req_idx == msi_idx_w'(`MSI_NUM_IRQ - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= req_idx + 1'b1;
      end
    end
  end

  // First pending line at or after the pointer
  always_comb begin
    int  pos;
    logic found;
    found   = 1'b0;
    req_idx = '0;
    for (int k = 0; k < `MSI_NUM_IRQ; k++) begin
      pos = int'(rr_ptr) + k;
      // Wrap around the line count
      if (pos >= `MSI_NUM_IRQ) begin
        pos = pos - `MSI_NUM_IRQ;
      end
      if (!found && pending[pos]) begin
        found   = 1'b1;
        req_idx = msi_idx_w'(pos);
      end
    end
  end

  assign req_valid = |pending;

endmodule

`default_nettype wire

// File: design/msi_throttle_timer.sv
//////////////////////////////////////////////////
// Throttle timer of the MSI bridge
// Down-counter loaded after each completed write,
// holds off new messages while nonzero
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_throttle_timer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  done,
  input  logic                  throttle_en,
  input  logic [`MSI_THR_W-1:0] throttle_threshold,
  output logic                  hold
);

  logic [`MSI_THR_W-1:0] count;

  // Load on done, then count down to zero
  // Hold covers exactly threshold cycles after done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (done && throttle_en) begin
      count <= throttle_threshold;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // Zero threshold gives no hold at all
  assign hold = (count != '0);

endmodule

`default_nettype wire

// File: design/msi_message_format.sv
//////////////////////////////////////////////////
// Message formatter of the MSI bridge
// Builds address, data and strobe for the granted
// line and keeps them registered for the write
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_message_format
  import msi_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 grant,
  input  logic [msi_idx_w-1:0]                 req_idx,
  input  logic [`MSI_ADDR_W-1:0]               msi_base_addr,
  input  msi_irq_cfg_t [`MSI_NUM_IRQ-1:0]      irq_cfg,
  output msi_msg_t                             msg
);

  // Bytes covered by the event id
  localparam int ev_bytes = (`MSI_EVID_W + 7) / 8;

  msi_irq_cfg_t cfg_sel;
  msi_msg_t     msg_next;

  // Configuration of the line being granted
  assign cfg_sel = irq_cfg[req_idx];

  // Base plus device id in word units, event id zero-extended
  always_comb begin
    msg_next.addr = msi_base_addr + `MSI_ADDR_W'({cfg_sel.device_id, 2'b00});
    msg_next.data = `MSI_DATA_W'(cfg_sel.event_id);
    msg_next.strb = `MSI_STRB_W'((1 << ev_bytes) - 1);
  end

  // Captured once per grant, stable for the whole write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msg <= '0;
    end else if (grant) begin
      msg <= msg_next;
    end
  end

endmodule

`default_nettype wire

// File: design/msi_write_fsm.sv
//////////////////////////////////////////////////
// Write sequencer of the MSI bridge
// Idle, grant, send and response states; drives
// AW and W together, takes the B response, and
// pulses done and error at the response
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module msi_write_fsm
  import msi_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  logic                   hold,
  input  msi_msg_t               msg,
  output logic                   grant,
  output logic                   done,
  output logic                   error,
  // AXI4-Lite write address channel
  output logic [`MSI_ADDR_W-1:0] awaddr,
  output logic                   awvalid,
  input  logic                   awready,
  // Write data channel
  output logic [`MSI_DATA_W-1:0] wdata,
  output logic [`MSI_STRB_W-1:0] wstrb,
  output logic                   wvalid,
  input  logic                   wready,
  // Write response channel
  input  logic [1:0]             bresp,
  input  logic                   bvalid,
  output logic                   bready
);

  typedef enum logic [1:0] {
    st_idle,
    st_grant,
    st_send,
    st_resp
  } state_t;

  state_t state;
  logic   aw_done;
  logic   w_done;
  logic   aw_hs;
  logic   w_hs;
  logic   send_end;

  // Channel handshakes this cycle
  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  // Both channels finished, in either order
  assign send_end = (aw_done || aw_hs) && (w_done || w_hs);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        // Wait for a pending line outside the throttle window
        st_idle: begin
          if (req_valid && !hold) begin
            state <= st_grant;
          end
        end
        // Grant cycle, message captured by the formatter
        st_grant: begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          state   <= st_send;
        end
        st_send: begin
          if (aw_hs) begin
            aw_done <= 1'b1;
          end
          if (w_hs) begin
            w_done <= 1'b1;
          end
          if (send_end) begin
            state <= st_resp;
          end
        end
        // One bvalid sample ends the write
        st_resp: begin
          if (bvalid) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign grant = (state == st_grant);

  // Valids rise together, drop on their own handshakes
  assign awvalid = (state == st_send) && !aw_done;
  assign wvalid  = (state == st_send) && !w_done;
  assign bready  = (state == st_resp);

  // Payload straight from the captured message
  assign awaddr = msg.addr;
  assign wdata  = msg.data;
  assign wstrb  = msg.strb;

  // Completion and error pulses
  assign done  = bready && bvalid;
  assign error = done && (bresp != `MSI_RESP_OKAY);

endmodule

`default_nettype wire

// File: design/axil_msi_gen.sv
//////////////////////////////////////////////////
// AXI4-Lite MSI generator, top level
// Pending logic, message formatter, write
// sequencer and throttle timer wired to the irq,
// configuration and write-only AXI4-Lite ports
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module axil_msi_gen
  import msi_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst_n,
  // Interrupt lines and per-line enables
  input  logic [`MSI_NUM_IRQ-1:0]         irq,
  input  logic [`MSI_NUM_IRQ-1:0]         msi_enable,
  // Message configuration
  input  logic [`MSI_ADDR_W-1:0]          msi_base_addr,
  input  msi_irq_cfg_t [`MSI_NUM_IRQ-1:0] irq_cfg,
  // Throttle configuration
  input  logic                            throttle_en,
  input  logic [`MSI_THR_W-1:0]           throttle_threshold,
  // Pulse on a non-OKAY response
  output logic                            error,
  // AXI4-Lite write-only initiator
  output logic [`MSI_ADDR_W-1:0]          awaddr,
  output logic                            awvalid,
  input  logic                            awready,
  output logic [`MSI_DATA_W-1:0]          wdata,
  output logic [`MSI_STRB_W-1:0]          wstrb,
  output logic                            wvalid,
  input  logic                            wready,
  input  logic [1:0]                      bresp,
  input  logic                            bvalid,
  output logic                            bready
);

  logic                 req_valid;
  logic [msi_idx_w-1:0] req_idx;
  logic                 grant;
  logic                 done;
  logic                 hold;
  msi_msg_t             msg;

  msi_irq_pending u_pending (
    .clk        (clk),
    .rst_n      (rst_n),
    .irq        (irq),
    .msi_enable (msi_enable),
    .grant      (grant),
    .req_valid  (req_valid),
    .req_idx    (req_idx)
  );

  msi_message_format u_format (
    .clk           (clk),
    .rst_n         (rst_n),
    .grant         (grant),
    .req_idx       (req_idx),
    .msi_base_addr (msi_base_addr),
    .irq_cfg       (irq_cfg),
    .msg           (msg)
  );

  msi_write_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .hold      (hold),
    .msg       (msg),
    .grant     (grant),
    .done      (done),
    .error     (error),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready)
  );

  msi_throttle_timer u_throttle (
    .clk                (clk),
    .rst_n              (rst_n),
    .done               (done),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .hold               (hold)
  );

endmodule

`default_nettype wire

// File: sim/axil_msi_props.sv
//////////////////////////////////////////////////
// AXI4-Lite write protocol checks for the MSI
// generator, bound into its top level
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module axil_msi_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic [`MSI_ADDR_W-1:0] awaddr,
  input logic                   awvalid,
  input logic                   awready,
  input logic [`MSI_DATA_W-1:0] wdata,
  input logic [`MSI_STRB_W-1:0] wstrb,
  input logic                   wvalid,
  input logic                   wready,
  input logic                   bvalid,
  input logic                   bready,
  input logic                   error
);

  // AW held until accepted
  a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");

  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> $stable(awaddr))
    else $error("awaddr changed while waiting for awready");

  // W held with stable data and strobe
  a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
    else $error("wvalid dropped or W payload changed before wready");

  // Both channels open in the same cycle
  a_valid_pair: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(awvalid) || $rose(wvalid) |-> $rose(awvalid) && $rose(wvalid))
    else $error("awvalid and wvalid did not rise together");

  // bready waits for the response
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bready && !bvalid |=> bready)
    else $error("bready dropped before bvalid");

  a_error_resp: assert property (@(posedge clk) disable iff (!rst_n)
    error |-> bvalid && bready)
    else $error("error pulse outside a B handshake");

endmodule

bind axil_msi_gen axil_msi_props u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .awaddr  (awaddr),
  .awvalid (awvalid),
  .awready (awready),
  .wdata   (wdata),
  .wstrb   (wstrb),
  .wvalid  (wvalid),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .error   (error)
);

`default_nettype wire

// File: sim/tb_axil_msi_gen.sv
//////////////////////////////////////////////////
// Testbench of the AXI4-Lite MSI generator
// Clock and reset, random interrupt and config
// stimulus, a responding AXI4-Lite target, the
// pending-set model and the checks against it
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "msi_defines.svh"

module tb_axil_msi_gen
  import msi_pkg::*;
();

  localparam int n_irq       = `MSI_NUM_IRQ;
  localparam int stim_cycles = 3000;
  localparam int phase_len   = 1000;
  localparam int drain_every = 250;
  localparam int idle_end    = 64;
  // Stimulus plus drain and throttle tails, with margin
  localparam int max_cycles  = 2 * stim_cycles;
  localparam int ev_bytes    = (`MSI_EVID_W + 7) / 8;

  logic                            clk;
  logic                            rst_n;
  logic [`MSI_NUM_IRQ-1:0]         irq;
  logic [`MSI_NUM_IRQ-1:0]         msi_enable;
  logic [`MSI_ADDR_W-1:0]          msi_base_addr;
  msi_irq_cfg_t [`MSI_NUM_IRQ-1:0] irq_cfg;
  logic                            throttle_en;
  logic [`MSI_THR_W-1:0]           throttle_threshold;
  logic                            error;
  logic [`MSI_ADDR_W-1:0]          awaddr;
  logic                            awvalid;
  logic                            awready;
  logic [`MSI_DATA_W-1:0]          wdata;
  logic [`MSI_STRB_W-1:0]          wstrb;
  logic                            wvalid;
  logic                            wready;
  logic [1:0]                      bresp;
  logic                            bvalid;
  logic                            bready;

  integer seed;
  int     cyc;

  // Model pending set, one cycle of history
  logic [`MSI_NUM_IRQ-1:0] m_pend;
  logic [`MSI_NUM_IRQ-1:0] m_pend_last;
  logic [`MSI_NUM_IRQ-1:0] m_rise_last;
  logic [`MSI_NUM_IRQ-1:0] irq_last;
  int                      rr_ptr;
  logic                    in_flight;
  logic                    awvalid_last;
  int                      writes;
  // Last B handshake for throttle spacing
  logic                    b_seen;
  int                      last_b_cyc;
  int                      last_b_thr;
  // Target side
  logic                    tgt_aw;
  logic                    tgt_w;
  logic                    tgt_armed;
  int                      tgt_wait;
  // Stimulus control
  logic                    drain;
  int                      idle_run;

  axil_msi_gen DUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .irq                (irq),
    .msi_enable         (msi_enable),
    .msi_base_addr      (msi_base_addr),
    .irq_cfg            (irq_cfg),
    .throttle_en        (throttle_en),
    .throttle_threshold (throttle_threshold),
    .error              (error),
    .awaddr             (awaddr),
    .awvalid            (awvalid),
    .awready            (awready),
    .wdata              (wdata),
    .wstrb              (wstrb),
    .wvalid             (wvalid),
    .wready             (wready),
    .bresp              (bresp),
    .bvalid             (bvalid),
    .bready             (bready)
  );

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic report_fail(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    report_fail($sformatf("mismatch at %0d ns: %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
  endtask

  // First pending line at or after the pointer, -1 when none
  function automatic int pick_next(logic [`MSI_NUM_IRQ-1:0] pend, int ptr);
    int pos;
    int found;
    found = -1;
    for (int k = 0; k < n_irq; k++) begin
      pos = (ptr + k) % n_irq;
      if (found < 0 && pend[pos]) begin
        found = pos;
      end
    end
    return found;
  endfunction

  // Payload held until handshake by the bound checks
  task automatic check_message(int idx);
    logic [`MSI_ADDR_W-1:0] exp_addr;
    logic [`MSI_DATA_W-1:0] exp_data;
    logic [`MSI_STRB_W-1:0] exp_strb;
    // Base plus device id in words
    exp_addr = msi_base_addr + (`MSI_ADDR_W'(irq_cfg[idx].device_id) << 2);
    exp_data = `MSI_DATA_W'(irq_cfg[idx].event_id);
    // Only the event id bytes
    for (int b = 0; b < `MSI_STRB_W; b++) begin
      exp_strb[b] = (b < ev_bytes);
    end
    assert (awaddr == exp_addr) else report_mismatch("awaddr", awaddr, exp_addr);
    assert (wdata == exp_data) else report_mismatch("wdata", wdata, exp_data);
    assert (wstrb == exp_strb) else report_mismatch("wstrb", 32'(wstrb), 32'(exp_strb));
  endtask

  task automatic check_cycle();
    logic [`MSI_NUM_IRQ-1:0] rise;
    logic [`MSI_NUM_IRQ-1:0] clr;
    logic                    exp_err;
    logic                    exp_bready;
    int                      idx;
    // Error only on a non-OKAY B handshake
    exp_err = bvalid && bready && (bresp != `MSI_RESP_OKAY);
    assert (error == exp_err) else report_mismatch("error", 32'(error), 32'(exp_err));
    // Response phase opens once the target took both channels
    exp_bready = tgt_aw && tgt_w;
    assert (bready == exp_bready)
      else report_mismatch("bready", 32'(bready), 32'(exp_bready));
    // An awvalid rise means a grant one cycle earlier
    if (awvalid && !awvalid_last) begin
      idx = pick_next(m_pend_last, rr_ptr);
      assert (idx >= 0) else report_fail("write started while no line was pending");
      check_message(idx);
      assert (!b_seen || (cyc - last_b_cyc >= last_b_thr + 2))
        else report_fail("write started inside the throttle window");
      clr = '0;
      clr[idx] = 1'b1;
      // Redo this cycle's set with the grant's clear
      m_pend = (m_pend_last & ~clr) | m_rise_last;
      rr_ptr = (idx + 1) % n_irq;
      in_flight = 1'b1;
      writes = writes + 1;
    end
    if (bvalid && bready) begin
      in_flight = 1'b0;
      b_seen = 1'b1;
      last_b_cyc = cyc;
      last_b_thr = throttle_en ? int'(throttle_threshold) : 0;
    end
    // Enabled rising edges, merged into the set
    rise = irq & ~irq_last & msi_enable;
    irq_last = irq;
    m_pend_last = m_pend;
    m_rise_last = rise;
    m_pend = m_pend | rise;
    awvalid_last = awvalid;
  endtask

  // Target with random ready stalls and B delay
  task automatic drive_target();
    logic [31:0] r;
    r = rand_word();
    awready <= (r[1:0] != 2'b00);
    wready <= (r[3:2] != 2'b00);
    if (awvalid && awready) begin
      tgt_aw = 1'b1;
    end
    if (wvalid && wready) begin
      tgt_w = 1'b1;
    end
    if (bvalid && bready) begin
      bvalid <= 1'b0;
      tgt_aw = 1'b0;
      tgt_w = 1'b0;
      tgt_armed = 1'b0;
    end else if (!bvalid && tgt_aw && tgt_w) begin
      if (!tgt_armed) begin
        tgt_armed = 1'b1;
        tgt_wait = int'(r[5:4]);
      end
      if (tgt_wait == 0) begin
        bvalid <= 1'b1;
        // SLVERR about one time in eight
        bresp <= (r[8:6] == 3'b000) ? 2'b10 : `MSI_RESP_OKAY;
      end else begin
        tgt_wait = tgt_wait - 1;
      end
    end
  endtask

  task automatic apply_config(int ph);
    logic [31:0]          r;
    logic [15:0]          dev;
    msi_irq_cfg_t         cfg;
    msi_base_addr <= rand_word();
    for (int i = 0; i < n_irq; i++) begin
      r = rand_word();
      // Line number in the low device id bits keeps messages distinct
      dev = r[15:0];
      dev[msi_idx_w-1:0] = msi_idx_w'(i);
      cfg.device_id = dev;
      cfg.event_id = r[31:16];
      irq_cfg[i] <= cfg;
    end
    r = rand_word();
    case (ph)
      0: begin
        throttle_en <= 1'b0;
        msi_enable <= '1;
      end
      1: begin
        throttle_en <= 1'b1;
        throttle_threshold <= `MSI_THR_W'(r[4:0]);
        msi_enable <= '1;
      end
      // Random enables, throttle either way
      default: begin
        throttle_en <= r[5];
        throttle_threshold <= `MSI_THR_W'(r[4:0]);
        msi_enable <= r[`MSI_NUM_IRQ+7:8];
      end
    endcase
  endtask

  task automatic finish_run();
    if (m_pend != '0) begin
      report_fail("run ended with interrupt lines still pending");
    end else begin
      $display("%0d messages written", writes);
      $display("TB PASSED");
      $finish;
    end
  endtask

  task automatic drive_stimulus(int stim_cyc);
    logic [31:0]             r;
    logic [`MSI_NUM_IRQ-1:0] flip;
    logic                    quiet;
    r = rand_word();
    quiet = (m_pend == '0) && !in_flight && !awvalid;
    if (!in_flight && !awvalid) begin
      idle_run = idle_run + 1;
    end else begin
      idle_run = 0;
    end
    if (stim_cyc % drain_every == 0) begin
      drain = 1'b1;
    end
    if (stim_cyc >= stim_cycles) begin
      // No more edges, wait out the last writes
      if (idle_run >= idle_end) begin
        finish_run();
      end
    end else if (drain) begin
      if (quiet) begin
        apply_config(stim_cyc / phase_len);
        drain = 1'b0;
      end
    end else begin
      // Each line toggles about once in eight cycles
      for (int i = 0; i < n_irq; i++) begin
        flip[i] = (r[3*i +: 3] == 3'b000);
      end
      irq <= irq ^ flip;
    end
  endtask

  initial begin
    seed = 71;
    cyc = 0;
    rst_n = 1'b0;
    irq = '0;
    msi_enable = '0;
    msi_base_addr = '0;
    irq_cfg = '0;
    throttle_en = 1'b0;
    throttle_threshold = '0;
    awready = 1'b0;
    wready = 1'b0;
    bresp = `MSI_RESP_OKAY;
    bvalid = 1'b0;
    m_pend = '0;
    m_pend_last = '0;
    m_rise_last = '0;
    irq_last = '0;
    rr_ptr = 0;
    in_flight = 1'b0;
    awvalid_last = 1'b0;
    writes = 0;
    b_seen = 1'b0;
    last_b_cyc = 0;
    last_b_thr = 0;
    tgt_aw = 1'b0;
    tgt_w = 1'b0;
    tgt_armed = 1'b0;
    tgt_wait = 0;
    drain = 1'b0;
    idle_run = 0;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= max_cycles) begin
      report_fail("timeout: run did not finish within the cycle limit");
    end else begin
      // Five reset edges, released on the fifth
      if (cyc == 5) begin
        rst_n <= 1'b1;
      end
      if (cyc >= 2 && cyc <= 6) begin
        assert (!awvalid && !wvalid && !bready && !error)
          else report_fail("valid, bready or error high during or right after reset");
      end
      if (cyc > 6) begin
        check_cycle();
        drive_target();
        drive_stimulus(cyc - 7);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
design/msi_pkg.sv
design/msi_irq_pending.sv
design/msi_throttle_timer.sv
design/msi_message_format.sv
design/msi_write_fsm.sv
design/axil_msi_gen.sv
sim/axil_msi_props.sv
sim/tb_axil_msi_gen.sv

// File: Makefile
# Verilator build and run of the MSI generator testbench

TOP := tb_axil_msi_gen

.PHONY: all run lint clean

all: run

# Build, run, and pass only if the pass line is printed
run:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
